// File: logic/fas_pkg.sv
//////////////////////////////////////////////////
// Shared widths, FIR and twiddle tables, and the frame types
// of the filter and spectrum chain. Imported by every RTL block
//////////////////////////////////////////////////
package fas_pkg;

  //////////////////////////////////////////////////
  // Widths and sizes
  //////////////////////////////////////////////////
  parameter int SAMPLE_W = 16;   // Input and filtered samples
  parameter int COEF_W   = 20;   // FIR coefficient word
  parameter int FRAC_W   = 16;   // Q16 fraction bits
  parameter int ACC_W    = 24;   // FFT datapath, 1 bit growth per stage
  parameter int N_TAPS   = 32;
  parameter int N_POINTS = 16;
  parameter int N_STAGES = 4;

  //////////////////////////////////////////////////
  // Symmetric low-pass FIR, tap 0 on the newest sample
  //////////////////////////////////////////////////
  parameter logic signed [COEF_W-1:0] fir_coef [N_TAPS] = '{
    20'shFFF9E, 20'shFFF86, 20'shFFFA7, 20'sh0003B,
    20'sh0014B, 20'sh0024A, 20'sh00222, 20'shFFFE4,
    20'shFFBC5, 20'shFF7CA, 20'shFF74E, 20'shFFD74,
    20'sh00B1A, 20'sh01DAC, 20'sh02F9E, 20'sh03AA9,
    20'sh03AA9, 20'sh02F9E, 20'sh01DAC, 20'sh00B1A,
    20'shFFD74, 20'shFF74E, 20'shFF7CA, 20'shFFBC5,
    20'shFFFE4, 20'sh00222, 20'sh0024A, 20'sh0014B,
    20'sh0003B, 20'shFFFA7, 20'shFFF86, 20'shFFF9E
  };

  //////////////////////////////////////////////////
  // Twiddles W16^k in Q16, k = 0..7
  //////////////////////////////////////////////////
  parameter logic signed [FRAC_W+1:0] tw_re [N_POINTS/2] = '{
    18'sd65536,  18'sd60547,  18'sd46340,  18'sd25079,
    18'sd0,     -18'sd25079, -18'sd46340, -18'sd60547
  };                                                    // cos(2*pi*k/16)

  parameter logic signed [FRAC_W+1:0] tw_im [N_POINTS/2] = '{
    18'sd0,     -18'sd25079, -18'sd46340, -18'sd60547,
   -18'sd65536, -18'sd60547, -18'sd46340, -18'sd25079
  };                                                    // -sin(2*pi*k/16)

  //////////////////////////////////////////////////
  // Data types
  //////////////////////////////////////////////////
  typedef logic signed [SAMPLE_W-1:0] sample_t;

  typedef struct packed {
    logic signed [ACC_W-1:0] re;
    logic signed [ACC_W-1:0] im;
  } cplx_t;                                             // 48 bits

  typedef cplx_t [N_POINTS-1:0] frame_t;                // Slot 0 in the low bits

  typedef struct packed {
    logic signed [SAMPLE_W-1:0] re;                     // Upper half
    logic signed [SAMPLE_W-1:0] im;
  } bin_t;

  typedef bin_t [N_POINTS-1:0] spectrum_t;              // Bin 0 in the low bits

  // Clamp a wide signed value into the 16-bit sample range
  function automatic sample_t sat_sample(input logic signed [2*ACC_W-1:0] v);
    logic signed [2*ACC_W-1:0] hi;
    logic signed [2*ACC_W-1:0] lo;
    hi = (2*ACC_W)'((1 <<< (SAMPLE_W - 1)) - 1);
    lo = -hi - 1;
    if (v > hi) begin
      return hi[SAMPLE_W-1:0];
    end else if (v < lo) begin
      return lo[SAMPLE_W-1:0];
    end
    return v[SAMPLE_W-1:0];
  endfunction

endpackage

// File: logic/fas_top.sv
//////////////////////////////////////////////////
// Filter and spectrum front end: FIR, framing, four FFT stages
// and the output packer. Spectrum follows a frame by 6 cycles
//////////////////////////////////////////////////
module fas_top import fas_pkg::*; #(
  parameter int TAPS   = N_TAPS,
  parameter int POINTS = N_POINTS
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      data_valid,
  input  sample_t   data,
  output logic      fir_valid,
  output sample_t   fir_d,
  output logic      fft_valid,
  output spectrum_t fft_d
);

  logic [N_STAGES:0] stg_valid;                // Index 0 is the collector output
  frame_t            stg_frame [N_STAGES+1];

  fir_filter #(.TAPS(TAPS)) u_fir (
    .clk        (clk),
    .rst        (rst),
    .data_valid (data_valid),
    .data       (data),
    .fir_valid  (fir_valid),
    .fir_d      (fir_d)
  );

  frame_collector #(.POINTS(POINTS)) u_collect (
    .clk         (clk),
    .rst         (rst),
    .fir_valid   (fir_valid),
    .fir_d       (fir_d),
    .frame_valid (stg_valid[0]),
    .frame       (stg_frame[0])
  );

  for (genvar s = 0; s < N_STAGES; s++) begin : g_stage
    fft_stage #(.STAGE(s)) u_stage (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (stg_valid[s]),
      .in_frame  (stg_frame[s]),
      .out_valid (stg_valid[s+1]),
      .out_frame (stg_frame[s+1])
    );
  end

  spectrum_packer u_pack (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (stg_valid[N_STAGES]),
    .in_frame  (stg_frame[N_STAGES]),
    .fft_valid (fft_valid),
    .fft_d     (fft_d)
  );

endmodule

// File: logic/fft_stage.sv
//////////////////////////////////////////////////
// One registered radix-2 DIF stage of the 16-point FFT.
// Span and twiddle stride follow from the stage index
//////////////////////////////////////////////////
module fft_stage import fas_pkg::*; #(
  parameter int STAGE = 0
) (
  input  logic   clk,
  input  logic   rst,
  input  logic   in_valid,
  input  frame_t in_frame,
  output logic   out_valid,
  output frame_t out_frame
);

  localparam int SPAN   = (N_POINTS / 2) >> STAGE;   // Butterfly distance
  localparam int STRIDE = 1 << STAGE;                // Twiddle index step
  localparam int PROD_W = ACC_W + FRAC_W + 3;

  frame_t nxt;

  //////////////////////////////////////////////////
  // Butterflies
  //////////////////////////////////////////////////
  always_comb begin
    cplx_t                    a;
    cplx_t                    b;
    cplx_t                    d;
    logic signed [PROD_W-1:0] pr;
    logic signed [PROD_W-1:0] pi;
    int                       t;

    nxt = in_frame;
    for (int k = 0; k < N_POINTS; k++) begin
      if ((k & SPAN) == 0) begin              // Upper half of the group
        a = in_frame[k];
        b = in_frame[k+SPAN];
        t = (k % SPAN) * STRIDE;

        nxt[k].re = a.re + b.re;
        nxt[k].im = a.im + b.im;

        d.re = a.re - b.re;
        d.im = a.im - b.im;

        // (d.re + j d.im) * (w.re + j w.im)
        pr = d.re * tw_re[t] - d.im * tw_im[t];
        pi = d.re * tw_im[t] + d.im * tw_re[t];

        nxt[k+SPAN].re = ACC_W'(pr >>> FRAC_W);   // Back to integer scale
        nxt[k+SPAN].im = ACC_W'(pi >>> FRAC_W);
      end
    end
  end

  //////////////////////////////////////////////////
  // Pipeline register
  //////////////////////////////////////////////////
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      out_valid <= 1'b0;
      out_frame <= '0;
    end else begin
      out_valid <= in_valid;
      out_frame <= nxt;                        // New frame every cycle
    end
  end

endmodule

// File: logic/fir_filter.sv
//////////////////////////////////////////////////
// Streaming low-pass FIR with a one-cycle registered dot product.
// Output is qualified once a full gap-free run fills the line
//////////////////////////////////////////////////
module fir_filter import fas_pkg::*; #(
  parameter int TAPS = N_TAPS
) (
  input  logic    clk,
  input  logic    rst,
  input  logic    data_valid,
  input  sample_t data,
  output logic    fir_valid,
  output sample_t fir_d
);

  localparam int CNT_W = $clog2(TAPS + 1);
  localparam int SUM_W = SAMPLE_W + COEF_W + $clog2(TAPS);

  sample_t                 line_q [TAPS];   // Delay line, index 0 newest
  sample_t                 line_d [TAPS];
  logic [CNT_W-1:0]        run_cnt;         // Accepted samples in this run
  logic [CNT_W-1:0]        run_next;
  logic signed [SUM_W-1:0] sum;

  //////////////////////////////////////////////////
  // Next line contents and dot product
  //////////////////////////////////////////////////
  always_comb begin
    line_d[0] = data;
    for (int i = 1; i < TAPS; i++) begin
      line_d[i] = line_q[i-1];
    end

    // Sum over the line as it will be after this sample
    sum = '0;
    for (int i = 0; i < TAPS; i++) begin
      sum = sum + line_d[i] * fir_coef[i];
    end

    if (run_cnt == CNT_W'(TAPS)) begin
      run_next = run_cnt;                   // Saturate once full
    end else begin
      run_next = run_cnt + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      line_q    <= '{default: '0};
      run_cnt   <= '0;
      fir_valid <= 1'b0;
      fir_d     <= '0;
    end else if (data_valid) begin
      line_q    <= line_d;
      run_cnt   <= run_next;
      fir_valid <= (run_next == CNT_W'(TAPS));
      fir_d     <= sat_sample((2*ACC_W)'(sum >>> FRAC_W));   // Q16 rescale
    end else begin
      // A gap restarts the fill count
      run_cnt   <= '0;
      fir_valid <= 1'b0;
    end
  end

endmodule

// File: logic/frame_collector.sv
//////////////////////////////////////////////////
// Serial to parallel framing of filtered samples into FFT frames
//////////////////////////////////////////////////
module frame_collector import fas_pkg::*; #(
  parameter int POINTS = N_POINTS
) (
  input  logic    clk,
  input  logic    rst,
  input  logic    fir_valid,
  input  sample_t fir_d,
  output logic    frame_valid,
  output frame_t  frame
);

  localparam int SLOT_W = $clog2(POINTS);

  logic [SLOT_W-1:0] slot;                    // Next slot to fill
  logic              last_slot;

  assign last_slot = (slot == SLOT_W'(POINTS - 1));

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      slot        <= '0;
      frame_valid <= 1'b0;
      frame       <= '0;
    end else if (fir_valid) begin
      frame[slot].re <= ACC_W'(fir_d);        // Sign-extended real input
      frame[slot].im <= '0;
      frame_valid    <= last_slot;
      if (last_slot) begin
        slot <= '0;
      end else begin
        slot <= slot + 1'b1;
      end
    end else begin
      // Partial frame is dropped on a gap
      slot        <= '0;
      frame_valid <= 1'b0;
    end
  end

endmodule

// File: logic/spectrum_packer.sv
//////////////////////////////////////////////////
// Reorders the DIF output into natural bin order and packs
// saturated 16-bit bins into the registered spectrum
//////////////////////////////////////////////////
module spectrum_packer import fas_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      in_valid,
  input  frame_t    in_frame,
  output logic      fft_valid,
  output spectrum_t fft_d
);

  spectrum_t spec_nxt;

  // Reverse the low N_STAGES bits of an index
  function automatic int bit_rev(input int k);
    int r;
    r = 0;
    for (int i = 0; i < N_STAGES; i++) begin
      r = r | (((k >> i) & 1) << (N_STAGES - 1 - i));
    end
    return r;
  endfunction

  always_comb begin
    cplx_t src;
    for (int k = 0; k < N_POINTS; k++) begin
      src            = in_frame[bit_rev(k)];             // DIF leaves bins bit-reversed
      spec_nxt[k].re = sat_sample((2*ACC_W)'(src.re));
      spec_nxt[k].im = sat_sample((2*ACC_W)'(src.im));
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      fft_valid <= 1'b0;
      fft_d     <= '0;
    end else begin
      fft_valid <= in_valid;
      fft_d     <= spec_nxt;
    end
  end

endmodule

// File: project.f
+incdir+verification
logic/fas_pkg.sv
logic/fir_filter.sv
logic/frame_collector.sv
logic/fft_stage.sv
logic/spectrum_packer.sv
logic/fas_top.sv
verification/fas_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the filter and spectrum testbench with Verilator and runs it.
# The run passes only if the log holds the pass line.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
  -f project.f \
  --top-module fas_tb \
  -o fas_sim

./obj_dir/fas_sim | tee sim.log

if grep -qx "TEST PASS" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see sim.log"
  exit 1
fi

// File: verification/fas_model.svh
//////////////////////////////////////////////////
// Reference model of the FIR, the 16-point DIF FFT and the LCG.
// Included inside the testbench module body
//////////////////////////////////////////////////
`ifndef FAS_MODEL_SVH
`define FAS_MODEL_SVH

// Next state of the stimulus generator
function automatic logic [31:0] lcg_next(input logic [31:0] s);
  return s * 32'd1103515245 + 32'd12345;
endfunction

// Clamp to the signed 16-bit range
function automatic sample_t clamp16(input longint v);
  sample_t r;
  if (v > 64'sd32767) begin
    r = 16'sh7FFF;
  end else if (v < -64'sd32768) begin
    r = 16'sh8000;
  end else begin
    r = sample_t'(v);
  end
  return r;
endfunction

// Filtered value over a delay line, h[0] newest
function automatic sample_t fir_response(input sample_t h [N_TAPS]);
  longint acc;
  acc = 0;
  for (int i = 0; i < N_TAPS; i++) begin
    acc = acc + longint'(h[i]) * longint'(fir_coef[i]);
  end
  return clamp16(acc >>> FRAC_W);     // Q16 rescale
endfunction

// Mirror the four index bits
function automatic int reverse_bits4(input int k);
  int r;
  r = 0;
  for (int i = 0; i < 4; i++) begin
    if (k[i]) begin
      r = r + (1 << (3 - i));
    end
  end
  return r;
endfunction

//////////////////////////////////////////////////
// Full spectrum of one real frame
//////////////////////////////////////////////////
function automatic spectrum_t fft_response(input longint x_re [N_POINTS]);
  longint    re [N_POINTS];
  longint    im [N_POINTS];
  longint    a_re;
  longint    a_im;
  longint    d_re;
  longint    d_im;
  longint    w_re;
  longint    w_im;
  int        span;
  int        tw;
  spectrum_t spec;

  for (int k = 0; k < N_POINTS; k++) begin
    re[k] = x_re[k];
    im[k] = 0;                        // Real input only
  end

  for (int s = 0; s < N_STAGES; s++) begin
    span = (N_POINTS / 2) >> s;
    for (int j = 0; j < N_POINTS; j++) begin
      if (((j / span) % 2) == 0) begin
        a_re = re[j];
        a_im = im[j];
        d_re = a_re - re[j+span];
        d_im = a_im - im[j+span];
        re[j] = a_re + re[j+span];
        im[j] = a_im + im[j+span];
        tw = (j % span) << s;         // Stride doubles per stage
        w_re = tw_re[tw];
        w_im = tw_im[tw];
        re[j+span] = (d_re * w_re - d_im * w_im) >>> FRAC_W;
        im[j+span] = (d_re * w_im + d_im * w_re) >>> FRAC_W;
      end
    end
  end

  // DIF leaves the bins in bit-reversed slots
  for (int k = 0; k < N_POINTS; k++) begin
    spec[k].re = clamp16(re[reverse_bits4(k)]);
    spec[k].im = clamp16(im[reverse_bits4(k)]);
  end
  return spec;
endfunction

`endif

// File: verification/fas_tb.sv
//////////////////////////////////////////////////
// Testbench for the filter and spectrum front end. Applies a table
// of input runs and checks every output cycle against the model
//////////////////////////////////////////////////
module fas_tb import fas_pkg::*; ();

  localparam int          CLK_PERIOD  = 40;
  localparam int          DRIVE_DLY   = 2;
  localparam int          DRAIN_LIMIT = 32;
  localparam logic [31:0] SEED        = 32'h23b5;
  localparam logic [1:0]  K_IMPULSE   = 2'd0;
  localparam logic [1:0]  K_CONST     = 2'd1;
  localparam logic [1:0]  K_RAMP      = 2'd2;
  localparam logic [1:0]  K_RANDOM    = 2'd3;
  localparam int          N_RUNS      = 7;

  typedef struct packed {
    logic [1:0]         kind;
    logic signed [15:0] amp;                      // Level or ramp start
    logic [15:0]        len;
    logic               gap;                      // Idle cycle afterwards
  } run_t;

  run_t runs [N_RUNS] = '{
    '{K_IMPULSE, 16'sd32767,  16'd48, 1'b1},
    '{K_RAMP,    -16'sd14000, 16'd20, 1'b1},      // Too short to qualify
    '{K_CONST,   16'sd10000,  16'd80, 1'b0},
    '{K_RANDOM,  16'sd0,      16'd96, 1'b1},
    '{K_RAMP,    -16'sd14000, 16'd40, 1'b1},      // Ends in a partial frame
    '{K_RANDOM,  16'sd0,      16'd70, 1'b1},
    '{K_CONST,   -16'sd20000, 16'd50, 1'b0}
  };

  logic      clk;
  logic      rst;
  logic      data_valid;
  sample_t   data;
  logic      fir_valid;
  sample_t   fir_d;
  logic      fft_valid;
  spectrum_t fft_d;

  // Model state
  sample_t     hist [N_TAPS];
  longint      frm_re [N_POINTS];
  int          run_len;
  int          slot;
  logic        exp_fir_valid;
  sample_t     exp_fir_d;
  spectrum_t   spec_q [$];
  int          due_q [$];                         // Cycle each spectrum is due
  int          cyc;
  int          n_checks;
  int          n_errors;
  int          n_spectra;
  int          n_expected;                        // Spectra the model has queued
  logic [31:0] lcg_state;

  `include "fas_model.svh"

  fas_top dut (
    .clk        (clk),
    .rst        (rst),
    .data_valid (data_valid),
    .data       (data),
    .fir_valid  (fir_valid),
    .fir_d      (fir_d),
    .fft_valid  (fft_valid),
    .fft_d      (fft_d)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic check_value(input string what, input longint got, input longint exp);
    n_checks++;
    if (got != exp) begin
      n_errors++;
      $display("error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  function automatic sample_t stimulus_sample(input run_t rn, input int i);
    sample_t x;
    case (rn.kind)
      K_IMPULSE: x = (i == 0) ? rn.amp : '0;
      K_CONST:   x = rn.amp;
      K_RAMP:    x = sample_t'(rn.amp + i * 700);
      default: begin
        lcg_state = lcg_next(lcg_state);
        x = sample_t'(lcg_state[31:16]);
      end
    endcase
    return x;
  endfunction

  //////////////////////////////////////////////////
  // Model update for the sample driven this cycle
  //////////////////////////////////////////////////
  task automatic model_step(input logic v, input sample_t x);
    if (v) begin
      for (int i = N_TAPS - 1; i > 0; i--) begin
        hist[i] = hist[i-1];
      end
      hist[0] = x;
      if (run_len < N_TAPS) begin
        run_len++;
      end
      exp_fir_valid = (run_len == N_TAPS);
      exp_fir_d = fir_response(hist);
    end else begin
      run_len = 0;                                // fir_d holds its value
      exp_fir_valid = 1'b0;
    end
    if (exp_fir_valid) begin
      frm_re[slot] = exp_fir_d;
      slot++;
      if (slot == N_POINTS) begin
        spec_q.push_back(fft_response(frm_re));
        due_q.push_back(cyc + 7);                 // 6 cycles after its fir_valid
        n_expected++;
        slot = 0;
      end
    end else begin
      slot = 0;
    end
  endtask

  task automatic check_spectrum();
    logic      exp_v;
    spectrum_t exp_s;
    exp_v = (due_q.size() > 0) && (due_q[0] == cyc);
    check_value("fft_valid", longint'(fft_valid), longint'(exp_v));
    if (exp_v) begin
      exp_s = spec_q.pop_front();
      void'(due_q.pop_front());
      if (fft_valid) begin
        for (int k = 0; k < N_POINTS; k++) begin
          check_value($sformatf("bin %0d re", k), fft_d[k].re, exp_s[k].re);
          check_value($sformatf("bin %0d im", k), fft_d[k].im, exp_s[k].im);
        end
        n_spectra++;
      end
    end
  endtask

  // Drive one cycle, then check what the previous cycle produced
  task automatic run_cycle(input logic v, input sample_t x);
    @(posedge clk);
    #(DRIVE_DLY);
    data_valid = v;
    data       = x;
    @(negedge clk);
    check_value("fir_valid", longint'(fir_valid), longint'(exp_fir_valid));
    check_value("fir_d", fir_d, exp_fir_d);
    check_spectrum();
    model_step(v, x);
    cyc++;
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////
  initial begin
    sample_t x;
    int      drain;

    rst           = 1'b1;
    data_valid    = 1'b0;
    data          = '0;
    hist          = '{default: '0};
    frm_re        = '{default: 0};
    run_len       = 0;
    slot          = 0;
    exp_fir_valid = 1'b0;
    exp_fir_d     = '0;
    cyc           = 0;
    n_checks      = 0;
    n_errors      = 0;
    n_spectra     = 0;
    n_expected    = 0;
    lcg_state     = SEED;

    repeat (2) @(posedge clk);
    #(DRIVE_DLY);
    rst = 1'b0;

    for (int r = 0; r < N_RUNS; r++) begin
      for (int i = 0; i < int'(runs[r].len); i++) begin
        x = stimulus_sample(runs[r], i);
        run_cycle(1'b1, x);
      end
      if (runs[r].gap) begin
        run_cycle(1'b0, '0);
      end
    end

    // Idle until the pipeline has delivered every spectrum
    run_cycle(1'b0, '0);
    drain = 0;
    while (n_spectra < n_expected && drain < DRAIN_LIMIT) begin
      run_cycle(1'b0, '0);
      drain++;
    end
    if (n_spectra < n_expected) begin
      $display("Timed out while waiting for %0d more spectra", n_expected - n_spectra);
      n_errors++;
    end

    $display("checks %0d, errors %0d, spectra %0d", n_checks, n_errors, n_spectra);
    if (n_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
